//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_game_move -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_game_move)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

//--- tb.f
verilog/tile_pkg.sv
verilog/board_stage_if.sv
verilog/move_decode.sv
verilog/line_merge.sv
verilog/merge_execute.sv
verilog/spawn_result.sv
verilog/game_move_top.sv
test/move_checker.sv
test/tb_game_move.sv

//--- test/move_checker.sv
`timescale 1ns/1ps
`default_nettype none

module move_checker #(
    parameter int NUM_TESTS = 9
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_ready,
    input  logic             out_valid,
    input  logic             out_ready,
    input  tile_pkg::board_t board_out,
    input  logic             movable,
    input  logic             full,
    input  tile_pkg::board_t exp_board,
    input  logic             exp_movable,
    input  logic             exp_full,
    output int               result_count,
    output int               pass_count,
    output int               fail_count
);
    import tile_pkg::*;

    task automatic check_value(input string name, input logic [79:0] exp_v,
                               input logic [79:0] got_v, inout logic ok);
        if (exp_v !== got_v) begin
            $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp_v, got_v);
            ok = 1'b0;
        end
    endtask

    initial begin : watch
        logic ok;
        result_count = 0;
        pass_count   = 0;
        fail_count   = 0;

        // Idle outputs right as reset is released
        @(negedge rst);
        ok = 1'b1;
        check_value("in_ready", 80'(1'b1), 80'(in_ready), ok);
        check_value("out_valid", 80'(1'b0), 80'(out_valid), ok);
        check_value("movable", 80'(1'b0), 80'(movable), ok);
        check_value("full", 80'(1'b0), 80'(full), ok);
        if (ok) begin
            pass_count++;
            $display("reset state ok");
        end else begin
            fail_count++;
            $display("reset state wrong");
        end

        forever begin
            @(posedge clk);
            if (!rst && out_valid && out_ready) begin
                ok = 1'b1;
                if (result_count >= NUM_TESTS) begin
                    $display("Extra result at %0t beyond the %0d table rows", $time, NUM_TESTS);
                    fail_count++;
                end else begin
                    check_value("board_out", exp_board, board_out, ok);
                    check_value("movable", 80'(exp_movable), 80'(movable), ok);
                    check_value("full", 80'(exp_full), 80'(full), ok);
                    if (ok) begin
                        pass_count++;
                        $display("test %0d ok  board_out %h movable %b full %b",
                                 result_count, board_out, movable, full);
                    end else begin
                        fail_count++;
                        $display("test %0d failed", result_count);
                    end
                end
                result_count++;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_game_move.sv
`timescale 1ns/1ps
`default_nettype none

module tb_game_move;
    import tile_pkg::*;

    localparam int ROLL_W      = 6;
    localparam int NUM_TESTS   = 9;
    localparam int PERIOD      = 100;
    localparam int WATCHDOG_NS = (NUM_TESTS * 24 + 16) * PERIOD * 2;

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic              in_ready;
    board_t            board_in;
    dir_t              dir;
    order_t            order;
    logic [ROLL_W-1:0] roll;
    logic              out_valid;
    logic              out_ready;
    board_t            board_out;
    logic              movable;
    logic              full;

    board_t            tab_board [NUM_TESTS];
    dir_t              tab_dir   [NUM_TESTS];
    order_t            tab_order [NUM_TESTS];
    logic [ROLL_W-1:0] tab_roll  [NUM_TESTS];
    board_t            tab_exp   [NUM_TESTS];
    logic              tab_mov   [NUM_TESTS];
    logic              tab_full  [NUM_TESTS];
    logic              tab_hold  [NUM_TESTS];   // Out_ready low while this row goes in
    int                n_cases;

    int         result_count;
    int         pass_count;
    int         fail_count;
    logic [3:0] exp_idx;

    assign exp_idx = result_count[3:0];

    game_move_top #(.ROLL_W(ROLL_W)) UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .board_in  (board_in),
        .dir       (dir),
        .order     (order),
        .roll      (roll),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .board_out (board_out),
        .movable   (movable),
        .full      (full)
    );

    move_checker #(.NUM_TESTS(NUM_TESTS)) u_checker (
        .clk          (clk),
        .rst          (rst),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .board_out    (board_out),
        .movable      (movable),
        .full         (full),
        .exp_board    (tab_exp[exp_idx]),
        .exp_movable  (tab_mov[exp_idx]),
        .exp_full     (tab_full[exp_idx]),
        .result_count (result_count),
        .pass_count   (pass_count),
        .fail_count   (fail_count)
    );

    // Hex digit k of the literal, read left to right, is cell k
    function automatic board_t cells_to_board(input logic [63:0] nib);
        board_t b;
        for (int p = 0; p < NUM_CELLS; p++) begin
            b[p / GRID_N][p % GRID_N] = cell_t'(nib[63 - 4 * p -: 4]);
        end
        return b;
    endfunction

    function automatic order_t digits_to_order(input logic [63:0] nib);
        order_t o;
        for (int k = 0; k < NUM_CELLS; k++) begin
            o[k] = nib[63 - 4 * k -: 4];
        end
        return o;
    endfunction

    task automatic add_case(input logic [63:0] b, input dir_t d, input logic [63:0] o,
                            input logic [ROLL_W-1:0] r, input logic [63:0] e,
                            input logic m, input logic f, input logic h);
        tab_board[n_cases] = cells_to_board(b);
        tab_dir[n_cases]   = d;
        tab_order[n_cases] = digits_to_order(o);
        tab_roll[n_cases]  = r;
        tab_exp[n_cases]   = cells_to_board(e);
        tab_mov[n_cases]   = m;
        tab_full[n_cases]  = f;
        tab_hold[n_cases]  = h;
        n_cases++;
    endtask

    task automatic fill_table();
        n_cases = 0;
        // Same mixed board in all four directions, row 0 holds four equal tiles
        add_case(64'h1111_2023_0004_3300, LEFT, 64'h0123_4567_89AB_CDEF, 6'd0,
                 64'h2220_3300_4000_4000, 1'b1, 1'b0, 1'b0);
        add_case(64'h1111_2023_0004_3300, UP, 64'h4A01_2356_789B_CDEF, 6'd5,
                 64'h1111_2323_3014_0000, 1'b1, 1'b0, 1'b0);
        add_case(64'h1111_2023_0004_3300, RIGHT, 64'h0123_4567_89AB_CDEF, 6'h3F,
                 64'h1022_0033_0004_0004, 1'b1, 1'b0, 1'b0);
        add_case(64'h1111_2023_0004_3300, DOWN, 64'h7601_2345_89AB_CDEF, 6'd1,
                 64'h0000_1011_2113_3324, 1'b1, 1'b0, 1'b0);
        add_case(64'h1200_3000_0000_0000, LEFT, 64'h0123_4567_89AB_CDEF, 6'd0,
                 64'h1200_3000_0000_0000, 1'b0, 1'b0, 1'b0);   // Dead move
        // Three requests stacked behind a stalled output
        add_case(64'h1100_0000_0000_0000, LEFT, 64'h0123_4567_89AB_CDEF, 6'd0,
                 64'h2200_0000_0000_0000, 1'b1, 1'b0, 1'b1);
        add_case(64'h0000_0000_0000_0011, RIGHT, 64'h0123_4567_89AB_CDEF, 6'd9,
                 64'h1000_0000_0000_0002, 1'b1, 1'b0, 1'b1);
        add_case(64'h0000_0000_0000_0005, DOWN, 64'h0123_4567_89AB_CDEF, 6'd0,
                 64'h0000_0000_0000_0005, 1'b0, 1'b0, 1'b1);
        // Order names only cell 0, which stays occupied
        add_case(64'h1123_1212_2121_1212, LEFT, 64'h0000_0000_0000_0000, 6'd3,
                 64'h2230_1212_2121_1212, 1'b1, 1'b1, 1'b0);
    endtask

    task automatic send_request(input int t);
        in_valid = 1'b1;
        board_in = tab_board[t];
        dir      = tab_dir[t];
        order    = tab_order[t];
        roll     = tab_roll[t];
        #(PERIOD / 4);   // In_ready has settled well before the rising edge
        while (!in_ready) begin
            @(negedge clk);
            #(PERIOD / 4);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the output of test %0d never arrived", result_count);
        $display("counts: %0d passed, %0d failed", pass_count, fail_count);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'hc9a1));
        rst       = 1'b1;
        in_valid  = 1'b0;
        board_in  = '0;
        dir       = LEFT;
        order     = '0;
        roll      = '0;
        out_ready = 1'b1;
        fill_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (tab_hold[t] && (t == 0 || !tab_hold[t-1])) begin
                wait (result_count == t);   // Stall starts from an empty pipeline
                @(negedge clk);
            end
            if (!tab_hold[t] && t > 0 && tab_hold[t-1]) begin
                repeat (20) @(negedge clk);   // Longest scan finishes while stalled
            end
            out_ready = !tab_hold[t];
            send_request(t);
        end
        out_ready = 1'b1;
        wait (result_count == NUM_TESTS);
        @(negedge clk);
        $display("counts: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/board_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface board_stage_if #(
    parameter int ROLL_W = 6
);
    import tile_pkg::*;

    logic              valid;
    logic              ready;
    board_t            board;
    dir_t              dir;
    order_t            order;
    logic [ROLL_W-1:0] roll;
    logic              moved;   // Only meaningful after execute

    modport src (
        output valid, board, dir, order, roll, moved,
        input  ready
    );

    modport dst (
        input  valid, board, dir, order, roll, moved,
        output ready
    );

endinterface

`default_nettype wire

//--- verilog/game_move_top.sv
`timescale 1ns/1ps
`default_nettype none

module game_move_top #(
    parameter int ROLL_W = 6
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  tile_pkg::board_t  board_in,
    input  tile_pkg::dir_t    dir,
    input  tile_pkg::order_t  order,
    input  logic [ROLL_W-1:0] roll,
    output logic              out_valid,
    input  logic              out_ready,
    output tile_pkg::board_t  board_out,
    output logic              movable,
    output logic              full
);

    board_stage_if #(.ROLL_W(ROLL_W)) dec2exe ();
    board_stage_if #(.ROLL_W(ROLL_W)) exe2res ();

    move_decode #(.ROLL_W(ROLL_W)) u_decode (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .board_in (board_in),
        .dir      (dir),
        .order    (order),
        .roll     (roll),
        .dn       (dec2exe)
    );

    merge_execute u_execute (
        .clk (clk),
        .rst (rst),
        .up  (dec2exe),
        .dn  (exe2res)
    );

    spawn_result #(.ROLL_W(ROLL_W)) u_result (
        .clk       (clk),
        .rst       (rst),
        .up        (exe2res),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .board_out (board_out),
        .movable   (movable),
        .full      (full)
    );

endmodule

`default_nettype wire

//--- verilog/line_merge.sv
`timescale 1ns/1ps
`default_nettype none

module line_merge (
    input  tile_pkg::row_t row_in,
    output tile_pkg::row_t row_out,
    output logic           moved
);
    import tile_pkg::*;

    cell_t comp_cells [GRID_N+1];   // Spare top slot stays zero

    // Slide the nonzero cells down to index 0, keeping their order
    always_comb begin : compact
        int n;
        n = 0;
        for (int k = 0; k <= GRID_N; k++) begin
            comp_cells[k] = '0;
        end
        for (int k = 0; k < GRID_N; k++) begin
            if (row_in[k] != '0) begin
                comp_cells[n] = row_in[k];
                n++;
            end
        end
    end

    // Pair equal neighbours from index 0 upward, each cell merges at most once
    always_comb begin : merge
        int   o;
        logic skip;
        o       = 0;
        skip    = 1'b0;
        row_out = '0;
        for (int k = 0; k < GRID_N; k++) begin
            if (skip) begin
                skip = 1'b0;   // Consumed by the previous merge
            end else if (comp_cells[k] != '0) begin
                if (comp_cells[k] == comp_cells[k+1]) begin
                    row_out[o] = comp_cells[k] + 1'b1;   // Wraps past 31
                    skip       = 1'b1;
                end else begin
                    row_out[o] = comp_cells[k];
                end
                o++;
            end
        end
    end

    assign moved = (row_out != row_in);

endmodule

`default_nettype wire

//--- verilog/merge_execute.sv
`timescale 1ns/1ps
`default_nettype none

module merge_execute (
    input logic        clk,
    input logic        rst,
    board_stage_if.dst up,
    board_stage_if.src dn
);
    import tile_pkg::*;

    board_t            merged;
    logic [GRID_N-1:0] row_moved;
    logic              take;

    assign up.ready = !dn.valid || dn.ready;
    assign take     = up.valid && up.ready;

    for (genvar r = 0; r < GRID_N; r++) begin : g_row
        line_merge u_line (
            .row_in  (up.board[r]),
            .row_out (merged[r]),
            .moved   (row_moved[r])
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dn.valid <= 1'b0;
        end else if (take) begin
            dn.valid <= 1'b1;
        end else if (dn.ready) begin
            dn.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dn.board <= merged;
            dn.moved <= |row_moved;   // Any row changed
            dn.dir   <= up.dir;
            dn.order <= up.order;
            dn.roll  <= up.roll;
        end
    end

endmodule

`default_nettype wire

//--- verilog/move_decode.sv
`timescale 1ns/1ps
`default_nettype none

module move_decode #(
    parameter int ROLL_W = 6
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  tile_pkg::board_t  board_in,
    input  tile_pkg::dir_t    dir,
    input  tile_pkg::order_t  order,
    input  logic [ROLL_W-1:0] roll,
    board_stage_if.src        dn
);
    import tile_pkg::*;

    board_t rotated;
    logic   take;

    assign in_ready = !dn.valid || dn.ready;   // Empty or draining
    assign take     = in_valid && in_ready;
    assign dn.moved = 1'b0;

    // Merge frame cell [i][j] picks its source cell by direction
    always_comb begin
        for (int i = 0; i < GRID_N; i++) begin
            for (int j = 0; j < GRID_N; j++) begin
                case (dir)
                    LEFT:    rotated[i][j] = board_in[i][j];
                    UP:      rotated[i][j] = board_in[j][i];
                    RIGHT:   rotated[i][j] = board_in[i][GRID_N-1-j];
                    default: rotated[i][j] = board_in[GRID_N-1-j][i];   // DOWN
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dn.valid <= 1'b0;
        end else if (take) begin
            dn.valid <= 1'b1;
        end else if (dn.ready) begin
            dn.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dn.board <= rotated;
            dn.dir   <= dir;
            dn.order <= order;
            dn.roll  <= roll;
        end
    end

endmodule

`default_nettype wire

//--- verilog/spawn_result.sv
`timescale 1ns/1ps
`default_nettype none

module spawn_result #(
    parameter int ROLL_W = 6
) (
    input  logic             clk,
    input  logic             rst,
    board_stage_if.dst       up,
    output logic             out_valid,
    input  logic             out_ready,
    output tile_pkg::board_t board_out,
    output logic             movable,
    output logic             full
);
    import tile_pkg::*;

    localparam int IDX_W = $clog2(GRID_N);

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DONE
    } state_t;

    state_t            state;
    board_t            board_q;
    board_t            unrotated;
    order_t            order_q;
    logic [ROLL_W-1:0] roll_q;
    logic [POS_W-1:0]  idx;       // Order entry under test
    logic [POS_W-1:0]  cur_pos;
    logic [IDX_W-1:0]  cur_row;
    logic [IDX_W-1:0]  cur_col;
    logic              hit;
    logic              take;

    assign up.ready  = (state == IDLE) || (state == DONE && out_ready);
    assign take      = up.valid && up.ready;
    assign out_valid = (state == DONE);
    assign board_out = board_q;

    assign cur_pos = order_q[idx];
    assign cur_row = cur_pos[POS_W-1 -: IDX_W];
    assign cur_col = cur_pos[IDX_W-1:0];
    assign hit     = (board_q[cur_row][cur_col] == '0);

    // Put each merge frame cell back where decode took it from
    always_comb begin
        for (int i = 0; i < GRID_N; i++) begin
            for (int j = 0; j < GRID_N; j++) begin
                case (up.dir)
                    LEFT:    unrotated[i][j] = up.board[i][j];
                    UP:      unrotated[j][i] = up.board[i][j];
                    RIGHT:   unrotated[i][GRID_N-1-j] = up.board[i][j];
                    default: unrotated[GRID_N-1-j][i] = up.board[i][j];   // DOWN
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            idx     <= '0;
            movable <= 1'b0;
            full    <= 1'b0;
        end else if (take) begin
            state   <= up.moved ? SCAN : DONE;   // No spawn on a dead move
            idx     <= '0;
            movable <= up.moved;
            full    <= 1'b0;
        end else begin
            case (state)
                SCAN: begin
                    if (hit) begin
                        state <= DONE;
                    end else if (idx == POS_W'(NUM_CELLS - 1)) begin
                        full  <= 1'b1;   // Order exhausted
                        state <= DONE;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                DONE: begin
                    if (out_ready) begin
                        state   <= IDLE;
                        movable <= 1'b0;
                        full    <= 1'b0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            board_q <= unrotated;
            order_q <= up.order;
            roll_q  <= up.roll;
        end else if (state == SCAN && hit) begin
            board_q[cur_row][cur_col] <= (roll_q == '0) ? SPAWN_LARGE : SPAWN_SMALL;
        end
    end

endmodule

`default_nettype wire

//--- verilog/tile_pkg.sv
`default_nettype none

package tile_pkg;

    localparam int CELL_W    = 5;   // Exponent bits, zero is an empty cell
    localparam int GRID_N    = 4;
    localparam int NUM_CELLS = GRID_N * GRID_N;
    localparam int POS_W     = 4;   // Row in the upper half, column in the lower

    typedef logic [CELL_W-1:0] cell_t;

    // Index 0 is the end the tiles slide toward
    typedef cell_t [GRID_N-1:0] row_t;

    // Cell p sits at bit CELL_W*p
    typedef row_t [GRID_N-1:0] board_t;

    // Entry 0 is tried first
    typedef logic [NUM_CELLS-1:0][POS_W-1:0] order_t;

    typedef enum logic [1:0] {
        LEFT  = 2'd0,
        UP    = 2'd1,
        RIGHT = 2'd2,
        DOWN  = 2'd3
    } dir_t;

    localparam cell_t SPAWN_SMALL = 5'd1;   // Nonzero roll
    localparam cell_t SPAWN_LARGE = 5'd2;   // Zero roll

endpackage

`default_nettype wire
